// File: src/pipePkg.sv
/* Shared widths, encodings and instruction views for the pipeline slice.
   insb/insh use opcodes 0x18/0x19 and take their lane from imm[1:0]. */
package pipePkg;

    localparam int dataW = 32;
    localparam int regAddrW = 5;
    localparam int laneCount = 4;
    localparam int laneSelW = 2;
    localparam int byteW = 8;
    localparam int memDepth = 16;
    localparam int memAddrW = $clog2(memDepth);

    // primary opcodes.
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opXori = 6'h0e;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opInsb = 6'h18;
    localparam logic [5:0] opInsh = 6'h19;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // function codes of the R-format group.
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluInsB,
        aluInsH
    } aluOpT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [15:0] imm;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrT;

endpackage

// File: src/fwdBus.sv
/* One pending register write as seen by the forwarding logic.
   isLoad is only meaningful on the execute instance. */
`timescale 1ns/1ps

interface fwdBus;
    import pipePkg::*;

    logic valid;
    logic [regAddrW-1:0] dest;
    logic [laneCount-1:0] byteEn;
    logic [dataW-1:0] value;
    logic isLoad; // value is an address, not the loaded word.

    modport src (
        output valid, dest, byteEn, value, isLoad
    );

    modport sink (
        input valid, dest, byteEn, value, isLoad
    );

endinterface

// File: src/decodeBus.sv
/* Decoded instruction bundle registered by decode and consumed by execute. */
`timescale 1ns/1ps

interface decodeBus;
    import pipePkg::*;

    logic valid;
    aluOpT aluOp;
    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [regAddrW-1:0] dest;
    logic [laneCount-1:0] byteEn;
    logic [laneSelW-1:0] lane;
    logic isLoad;
    logic isStore;
    logic [dataW-1:0] storeData;
    logic stale;

    modport producer (
        output valid, aluOp, opA, opB, dest, byteEn, lane,
        output isLoad, isStore, storeData, stale
    );

    modport consumer (
        input valid, aluOp, opA, opB, dest, byteEn, lane,
        input isLoad, isStore, storeData, stale
    );

endinterface

// File: src/regFile.sv
/* 32 x 32 register file, byte-enable writes from the writeback record.
   Reads forward per byte lane; a pending load in execute is never forwarded.
   Register contents are undefined until written. */
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic [pipePkg::regAddrW-1:0] rs1Addr,
    input  logic [pipePkg::regAddrW-1:0] rs2Addr,
    output logic [pipePkg::dataW-1:0] rs1Data,
    output logic [pipePkg::dataW-1:0] rs2Data,
    fwdBus.sink exFwd,
    fwdBus.sink resFwd,
    fwdBus.sink wbFwd
);
    import pipePkg::*;

    logic [laneCount-1:0][byteW-1:0] regs [2**regAddrW];

    logic [regAddrW-1:0] rdAddr [2];
    logic [1:0][laneCount-1:0][byteW-1:0] rdBytes;

    assign rdAddr[0] = rs1Addr;
    assign rdAddr[1] = rs2Addr;
    assign rs1Data = rdBytes[0];
    assign rs2Data = rdBytes[1];

    always_ff @(posedge clk) begin
        if (wbFwd.valid && wbFwd.dest != '0) begin
            for (int b = 0; b < laneCount; b++) begin
                if (wbFwd.byteEn[b]) begin
                    regs[wbFwd.dest][b] <= wbFwd.value[byteW*b +: byteW];
                end
            end
        end
    end

    // each byte of each read port picks its own youngest source.
    for (genvar p = 0; p < 2; p++) begin : gPort
        for (genvar b = 0; b < laneCount; b++) begin : gLane
            logic exHit;
            logic resHit;
            logic wbHit;

            assign exHit = exFwd.valid && !exFwd.isLoad && exFwd.byteEn[b]
                           && exFwd.dest == rdAddr[p];
            assign resHit = resFwd.valid && resFwd.byteEn[b]
                            && resFwd.dest == rdAddr[p];
            assign wbHit = wbFwd.valid && wbFwd.byteEn[b]
                           && wbFwd.dest == rdAddr[p];

            assign rdBytes[p][b] =
                (rdAddr[p] == '0) ? '0 :
                exHit  ? exFwd.value[byteW*b +: byteW] :
                resHit ? resFwd.value[byteW*b +: byteW] :
                wbHit  ? wbFwd.value[byteW*b +: byteW] :
                regs[rdAddr[p]][b];
        end
    end

endmodule

// File: src/decodeStage.sv
/* Decode stage. Unknown opcodes retire with zero byte enables.
   A load-use at distance 1 is not stalled; the record is flagged stale. */
`timescale 1ns/1ps

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,
    input  pipePkg::instrT instr,
    fwdBus.sink exFwd,
    fwdBus.sink resFwd,
    fwdBus.sink wbFwd,
    decodeBus.producer dBus
);
    import pipePkg::*;

    aluOpT aluOp;
    logic useRs;
    logic useRt;
    logic useImm;
    logic isShift;
    logic isLoad;
    logic isStore;
    logic writes;
    logic [dataW-1:0] immVal;
    logic [regAddrW-1:0] dest;
    logic [laneSelW-1:0] lane;
    logic [laneCount-1:0] byteEn;
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [dataW-1:0] rs1Data;
    logic [dataW-1:0] rs2Data;
    logic stale;

    always_comb begin
        aluOp = aluAdd;
        useRs = 1'b0;
        useRt = 1'b0;
        useImm = 1'b1;
        isShift = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        writes = 1'b1;
        immVal = {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm};
        dest = instr.iFmt.rt;
        lane = '0;
        byteEn = '1;
        unique case (instr.iFmt.opcode)
            opRType: begin
                useRs = 1'b1;
                useRt = 1'b1;
                useImm = 1'b0;
                dest = instr.rFmt.rd;
                unique case (instr.rFmt.funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnSlt: aluOp = aluSlt;
                    fnSll: begin
                        aluOp = aluSll;
                        isShift = 1'b1;
                        useRs = 1'b0;
                    end
                    fnSrl: begin
                        aluOp = aluSrl;
                        isShift = 1'b1;
                        useRs = 1'b0;
                    end
                    default: writes = 1'b0;
                endcase
            end
            opAddi: useRs = 1'b1;
            opAndi: begin
                useRs = 1'b1;
                aluOp = aluAnd;
                immVal = {16'h0000, instr.iFmt.imm};
            end
            opOri: begin
                useRs = 1'b1;
                aluOp = aluOr;
                immVal = {16'h0000, instr.iFmt.imm};
            end
            opXori: begin
                useRs = 1'b1;
                aluOp = aluXor;
                immVal = {16'h0000, instr.iFmt.imm};
            end
            opLui: begin
                aluOp = aluOr; // rs reads as zero, so the result is the shifted immediate.
                immVal = {instr.iFmt.imm, 16'h0000};
            end
            opLw: begin
                useRs = 1'b1;
                isLoad = 1'b1;
            end
            opSw: begin
                useRs = 1'b1;
                useRt = 1'b1;
                isStore = 1'b1;
                writes = 1'b0;
            end
            opInsb: begin
                useRs = 1'b1;
                aluOp = aluInsB;
                lane = instr.iFmt.imm[1:0];
                byteEn = 4'b0001 << lane;
            end
            opInsh: begin
                useRs = 1'b1;
                aluOp = aluInsH;
                lane = {instr.iFmt.imm[1], 1'b0};
                byteEn = 4'b0011 << lane;
            end
            default: writes = 1'b0;
        endcase
        if (!writes || dest == '0) begin
            byteEn = '0;
        end
    end

    assign rs1Addr = useRs ? instr.rFmt.rs : '0;
    assign rs2Addr = useRt ? instr.rFmt.rt : '0;

    regFile rf (
        .clk(clk),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .exFwd(exFwd),
        .resFwd(resFwd),
        .wbFwd(wbFwd)
    );

    // the load in execute has no data yet, so the operand came from older state.
    assign stale = exFwd.valid && exFwd.isLoad
                   && ((rs1Addr != '0 && rs1Addr == exFwd.dest)
                       || (rs2Addr != '0 && rs2Addr == exFwd.dest));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dBus.valid <= 1'b0;
        end else begin
            dBus.valid <= instrValid;
        end
        dBus.aluOp <= aluOp;
        dBus.opA <= isShift ? rs2Data : rs1Data;
        dBus.opB <= isShift ? dataW'(instr.rFmt.shamt) : (useImm ? immVal : rs2Data);
        dBus.dest <= dest;
        dBus.byteEn <= byteEn;
        dBus.lane <= lane;
        dBus.isLoad <= isLoad;
        dBus.isStore <= isStore;
        dBus.storeData <= rs2Data;
        dBus.stale <= stale;
    end

endmodule

// File: src/executeStage.sv
/* Execute stage: ALU, insb/insh lane placement and the execute-to-result register.
   For loads and stores the ALU value is the effective address. */
`timescale 1ns/1ps

module executeStage (
    input  logic clk,
    input  logic rstN,
    decodeBus.consumer dBus,
    fwdBus.src exFwd,
    output logic resValid,
    output logic [pipePkg::regAddrW-1:0] resDest,
    output logic [pipePkg::laneCount-1:0] resByteEn,
    output logic [pipePkg::dataW-1:0] resValue,
    output logic resIsLoad,
    output logic resIsStore,
    output logic [pipePkg::dataW-1:0] resStoreData,
    output logic resStale
);
    import pipePkg::*;

    logic [dataW-1:0] aluVal;
    logic [4:0] laneShift;

    assign laneShift = {dBus.lane, 3'b000};

    always_comb begin
        unique case (dBus.aluOp)
            aluAdd: aluVal = dBus.opA + dBus.opB;
            aluSub: aluVal = dBus.opA - dBus.opB;
            aluAnd: aluVal = dBus.opA & dBus.opB;
            aluOr: aluVal = dBus.opA | dBus.opB;
            aluXor: aluVal = dBus.opA ^ dBus.opB;
            aluSlt: aluVal = dataW'($signed(dBus.opA) < $signed(dBus.opB));
            aluSll: aluVal = dBus.opA << dBus.opB[4:0];
            aluSrl: aluVal = dBus.opA >> dBus.opB[4:0];
            // the unselected lanes stay zero.
            aluInsB: aluVal = {24'h000000, dBus.opA[7:0]} << laneShift;
            aluInsH: aluVal = {16'h0000, dBus.opA[15:0]} << laneShift;
            default: aluVal = '0;
        endcase
    end

    assign exFwd.valid = dBus.valid;
    assign exFwd.dest = dBus.dest;
    assign exFwd.byteEn = dBus.byteEn;
    assign exFwd.value = aluVal;
    assign exFwd.isLoad = dBus.isLoad;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= dBus.valid;
        end
        resDest <= dBus.dest;
        resByteEn <= dBus.byteEn;
        resValue <= aluVal;
        resIsLoad <= dBus.isLoad;
        resIsStore <= dBus.isStore;
        resStoreData <= dBus.storeData;
        resStale <= dBus.stale;
    end

endmodule

// File: src/resultStage.sv
/* Result stage with a 16-word scratchpad indexed by address bits [5:2].
   Upper address bits alias; scratchpad contents are undefined until stored. */
`timescale 1ns/1ps

module resultStage (
    input  logic clk,
    input  logic rstN,
    input  logic resValid,
    input  logic [pipePkg::regAddrW-1:0] resDest,
    input  logic [pipePkg::laneCount-1:0] resByteEn,
    input  logic [pipePkg::dataW-1:0] resValue,
    input  logic resIsLoad,
    input  logic resIsStore,
    input  logic [pipePkg::dataW-1:0] resStoreData,
    input  logic resStale,
    fwdBus.src resFwd,
    fwdBus.src wbFwd,
    output logic wbStale
);
    import pipePkg::*;

    logic [dataW-1:0] scratch [memDepth];
    logic [memAddrW-1:0] memIdx;
    logic [dataW-1:0] resultVal;

    assign memIdx = resValue[memAddrW+1:2];
    assign resultVal = resIsLoad ? scratch[memIdx] : resValue; // asynchronous read.

    always_ff @(posedge clk) begin
        if (resValid && resIsStore) begin
            scratch[memIdx] <= resStoreData;
        end
    end

    assign resFwd.valid = resValid;
    assign resFwd.dest = resDest;
    assign resFwd.byteEn = resByteEn;
    assign resFwd.value = resultVal;
    assign resFwd.isLoad = 1'b0; // loaded data is known in this stage.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbFwd.valid <= 1'b0;
        end else begin
            wbFwd.valid <= resValid;
        end
        wbFwd.dest <= resDest;
        wbFwd.byteEn <= resByteEn;
        wbFwd.value <= resultVal;
        wbStale <= resStale;
    end

    assign wbFwd.isLoad = 1'b0;

endmodule

// File: src/pipeTop.sv
/* Three-stage pipeline slice. One wbValid pulse per instruction, 3 cycles after issue.
   There is no back-pressure; instrValid may be high every cycle. */
`timescale 1ns/1ps

module pipeTop (
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,
    input  logic [pipePkg::dataW-1:0] instr,
    output logic wbValid,
    output logic [pipePkg::regAddrW-1:0] wbDest,
    output logic [pipePkg::laneCount-1:0] wbByteEn,
    output logic [pipePkg::dataW-1:0] wbData,
    output logic wbStale
);
    import pipePkg::*;

    fwdBus exFwd ();
    fwdBus resFwd ();
    fwdBus wbFwd ();
    decodeBus dBus ();

    logic resValid;
    logic [regAddrW-1:0] resDest;
    logic [laneCount-1:0] resByteEn;
    logic [dataW-1:0] resValue;
    logic resIsLoad;
    logic resIsStore;
    logic [dataW-1:0] resStoreData;
    logic resStale;

    decodeStage decode (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .exFwd(exFwd),
        .resFwd(resFwd),
        .wbFwd(wbFwd),
        .dBus(dBus)
    );

    executeStage execute (
        .clk(clk),
        .rstN(rstN),
        .dBus(dBus),
        .exFwd(exFwd),
        .resValid(resValid),
        .resDest(resDest),
        .resByteEn(resByteEn),
        .resValue(resValue),
        .resIsLoad(resIsLoad),
        .resIsStore(resIsStore),
        .resStoreData(resStoreData),
        .resStale(resStale)
    );

    resultStage result (
        .clk(clk),
        .rstN(rstN),
        .resValid(resValid),
        .resDest(resDest),
        .resByteEn(resByteEn),
        .resValue(resValue),
        .resIsLoad(resIsLoad),
        .resIsStore(resIsStore),
        .resStoreData(resStoreData),
        .resStale(resStale),
        .resFwd(resFwd),
        .wbFwd(wbFwd),
        .wbStale(wbStale)
    );

    assign wbValid = wbFwd.valid;
    assign wbDest = wbFwd.dest;
    assign wbByteEn = wbFwd.byteEn;
    assign wbData = wbFwd.value;

endmodule

// File: verification/pipeTb.sv
/* Testbench for pipeTop. Expected records come from a shadow register and memory model.
   Data is compared only on the enabled lanes, so unselected insb/insh lanes are free. */
`timescale 1ns/1ps

module pipeTb;
    import pipePkg::*;

    localparam int resetCycles = 5;
    localparam int latency = 3;

    logic clk = 1'b0;
    logic rstN;
    logic instrValid;
    logic [dataW-1:0] instr;
    logic wbValid;
    logic [regAddrW-1:0] wbDest;
    logic [laneCount-1:0] wbByteEn;
    logic [dataW-1:0] wbData;
    logic wbStale;

    instrT prog [$];
    int gapQ [$];
    logic [regAddrW-1:0] expDest [$];
    logic [laneCount-1:0] expEn [$];
    logic [dataW-1:0] expData [$];
    logic expStale [$];
    int issueCyc [$];
    int pending [$]; // entries issued but not yet retired.
    logic [dataW-1:0] shadow [2**regAddrW];
    logic [dataW-1:0] shadowMem [memDepth];
    int cyc = 0;
    int cycleLimit = 0;
    int passCount = 0;
    int failCount = 0;
    int protoErrors = 0;

    pipeTop dut_i (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .wbValid(wbValid),
        .wbDest(wbDest),
        .wbByteEn(wbByteEn),
        .wbData(wbData),
        .wbStale(wbStale)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic instrT rOp(logic [5:0] fn, logic [regAddrW-1:0] rd,
                                  logic [regAddrW-1:0] rs, logic [regAddrW-1:0] rt,
                                  logic [4:0] sh);
        instrT w;
        w.rFmt.opcode = opRType;
        w.rFmt.rs = rs;
        w.rFmt.rt = rt;
        w.rFmt.rd = rd;
        w.rFmt.shamt = sh;
        w.rFmt.funct = fn;
        return w;
    endfunction

    function automatic instrT iOp(logic [5:0] op, logic [regAddrW-1:0] rt,
                                  logic [regAddrW-1:0] rs, logic [15:0] imm);
        instrT w;
        w.iFmt.opcode = op;
        w.iFmt.rs = rs;
        w.iFmt.rt = rt;
        w.iFmt.imm = imm;
        return w;
    endfunction

    task automatic addEntry(instrT w, int gap);
        prog.push_back(w);
        gapQ.push_back(gap);
    endtask

    // a register read right behind a load sees the value from before that load.
    function automatic logic [dataW-1:0] srcVal(logic [regAddrW-1:0] r,
                                                logic [regAddrW-1:0] hz,
                                                logic [dataW-1:0] oldVal);
        if (r == '0) begin
            return '0;
        end
        return (r == hz) ? oldVal : shadow[r];
    endfunction

    task automatic predict();
        instrT w;
        logic [dataW-1:0] a;
        logic [dataW-1:0] b;
        logic [dataW-1:0] res;
        logic [dataW-1:0] addr;
        logic [dataW-1:0] immS;
        logic [dataW-1:0] immZ;
        logic [dataW-1:0] loadOld;
        logic [regAddrW-1:0] dst;
        logic [regAddrW-1:0] hz;
        logic [regAddrW-1:0] loadDst;
        logic [laneCount-1:0] en;
        logic isR;
        logic readRs;
        logic readRt;
        loadDst = '0;
        loadOld = '0;
        for (int i = 0; i < prog.size(); i++) begin
            w = prog[i];
            hz = (gapQ[i] == 0) ? loadDst : '0;
            isR = w.iFmt.opcode == opRType;
            readRs = w.iFmt.opcode != opLui
                     && !(isR && (w.rFmt.funct == fnSll || w.rFmt.funct == fnSrl));
            readRt = isR || w.iFmt.opcode == opSw;
            a = srcVal(w.rFmt.rs, hz, loadOld);
            b = srcVal(w.rFmt.rt, hz, loadOld);
            immS = {{16{w.iFmt.imm[15]}}, w.iFmt.imm};
            immZ = {16'h0000, w.iFmt.imm};
            addr = a + immS;
            dst = w.iFmt.rt;
            en = '1;
            case (w.iFmt.opcode)
                opRType: begin
                    dst = w.rFmt.rd;
                    case (w.rFmt.funct)
                        fnAdd: res = a + b;
                        fnSub: res = a - b;
                        fnAnd: res = a & b;
                        fnOr: res = a | b;
                        fnXor: res = a ^ b;
                        fnSlt: res = ($signed(a) < $signed(b)) ? 1 : 0;
                        fnSll: res = b << w.rFmt.shamt;
                        default: res = b >> w.rFmt.shamt;
                    endcase
                end
                opAddi: res = a + immS;
                opAndi: res = a & immZ;
                opOri: res = a | immZ;
                opXori: res = a ^ immZ;
                opLui: res = {w.iFmt.imm, 16'h0000};
                opLw: res = shadowMem[addr[memAddrW+1:2]];
                opSw: begin
                    shadowMem[addr[memAddrW+1:2]] = b;
                    res = '0;
                    en = '0;
                end
                opInsb: begin
                    res = {4{a[7:0]}};
                    en = 4'b0001 << w.iFmt.imm[1:0];
                end
                default: begin
                    res = {2{a[15:0]}}; // insh, lane 0 or 2.
                    en = w.iFmt.imm[1] ? 4'b1100 : 4'b0011;
                end
            endcase
            if (dst == '0) begin
                en = '0;
            end
            expStale.push_back(hz != '0 && ((readRs && w.rFmt.rs == hz)
                                            || (readRt && w.rFmt.rt == hz)));
            loadDst = (w.iFmt.opcode == opLw) ? dst : '0;
            loadOld = shadow[dst];
            for (int l = 0; l < laneCount; l++) begin
                if (en[l]) begin
                    shadow[dst][byteW*l +: byteW] = res[byteW*l +: byteW];
                end
            end
            expDest.push_back(dst);
            expEn.push_back(en);
            expData.push_back(res);
        end
    endtask

    task automatic checkRecord();
        int idx;
        int errs;
        logic [dataW-1:0] mask;
        errs = 0;
        if (wbValid !== 1'b1) begin
            $display("wbValid is unknown at cycle %0d", cyc);
            protoErrors++;
        end else if (pending.size() == 0) begin
            $display("wbValid pulsed at cycle %0d with no instruction outstanding", cyc);
            protoErrors++;
        end else begin
            idx = pending.pop_front();
            if (cyc != issueCyc[idx] + latency) begin
                $display("entry %0d retired at cycle %0d instead of cycle %0d",
                         idx, cyc, issueCyc[idx] + latency);
                errs++;
            end
            if (expEn[idx] != '0 && wbDest !== expDest[idx]) begin
                $display("FAIL entry %0d wbDest got %h expected %h", idx, wbDest, expDest[idx]);
                errs++;
            end
            if (wbByteEn !== expEn[idx]) begin
                $display("FAIL entry %0d wbByteEn got %h expected %h",
                         idx, wbByteEn, expEn[idx]);
                errs++;
            end
            for (int l = 0; l < laneCount; l++) begin
                mask[byteW*l +: byteW] = {byteW{expEn[idx][l]}};
            end
            if ((wbData & mask) !== (expData[idx] & mask)) begin
                $display("FAIL entry %0d wbData got %h expected %h (lane mask %h)",
                         idx, wbData, expData[idx], mask);
                errs++;
            end
            if (wbStale !== expStale[idx]) begin
                $display("FAIL entry %0d wbStale got %h expected %h",
                         idx, wbStale, expStale[idx]);
                errs++;
            end
            if (errs == 0) begin
                passCount++;
                $display("entry %0d instr %h passed", idx, prog[idx]);
            end else begin
                failCount++;
                $display("entry %0d instr %h failed with %0d errors", idx, prog[idx], errs);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstN && wbValid !== 1'b0) begin
            checkRecord();
        end
    end

    initial begin : watchdog
        wait (cycleLimit > 0 && cyc >= cycleLimit);
        $display("run stopped after %0d cycles with %0d records outstanding",
                 cyc, pending.size());
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [dataW-1:0] rnd;
        int gapSum;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        void'($urandom(32'hd341_ce67));
        for (int r = 1; r <= 6; r++) begin
            rnd = $urandom;
            addEntry(iOp(opLui, regAddrW'(r), 0, rnd[31:16]), 3);
            addEntry(iOp(opOri, regAddrW'(r), regAddrW'(r), rnd[15:0]), 0);
        end
        // ALU and immediate ops, spaced so operands come from the array.
        addEntry(rOp(fnAdd, 7, 1, 2, 0), 3);
        addEntry(rOp(fnSub, 8, 1, 2, 0), 3);
        addEntry(rOp(fnAnd, 9, 3, 4, 0), 3);
        addEntry(rOp(fnOr, 10, 3, 4, 0), 3);
        addEntry(rOp(fnXor, 11, 5, 6, 0), 3);
        addEntry(rOp(fnSlt, 12, 1, 2, 0), 3);
        addEntry(rOp(fnSlt, 13, 2, 1, 0), 3);
        addEntry(rOp(fnSll, 14, 0, 3, 5), 3);
        addEntry(rOp(fnSrl, 15, 0, 4, 7), 3);
        addEntry(iOp(opAddi, 16, 1, 16'hff9c), 3);
        addEntry(iOp(opAndi, 17, 2, 16'hf0f0), 3);
        addEntry(iOp(opOri, 18, 3, 16'h8001), 3);
        addEntry(iOp(opXori, 19, 4, 16'hffff), 3);
        addEntry(iOp(opLui, 20, 0, 16'ha5c3), 3);
        // dependency chain at distances 1, 2 and 3.
        addEntry(rOp(fnAdd, 21, 1, 2, 0), 3);
        addEntry(rOp(fnSub, 22, 21, 3, 0), 0);
        addEntry(rOp(fnXor, 23, 21, 22, 0), 0);
        addEntry(rOp(fnOr, 24, 21, 23, 0), 0);
        addEntry(iOp(opAddi, 25, 24, 16'h0005), 0);
        // lane inserts, then a full read that merges ex, result and wb bytes.
        addEntry(rOp(fnAdd, 26, 5, 0, 0), 3);
        addEntry(iOp(opInsb, 26, 1, 16'h0002), 0);
        addEntry(iOp(opInsh, 26, 2, 16'h0000), 0);
        addEntry(iOp(opInsb, 26, 3, 16'h0003), 0);
        addEntry(rOp(fnAdd, 27, 26, 0, 0), 0);
        addEntry(iOp(opInsh, 26, 4, 16'h0002), 3);
        // stores, loads and writes to register 0.
        addEntry(iOp(opSw, 1, 0, 16'h0008), 3);
        addEntry(iOp(opSw, 2, 0, 16'h0024), 0);
        addEntry(iOp(opLw, 28, 0, 16'h0008), 1);
        addEntry(iOp(opLw, 29, 0, 16'h0024), 0);
        addEntry(rOp(fnAdd, 0, 1, 2, 0), 0);
        addEntry(iOp(opAddi, 0, 0, 16'h0007), 0);
        addEntry(rOp(fnAdd, 30, 0, 1, 0), 0);
        // load-use at distance 1 through rs and rt, then at distance 2.
        addEntry(iOp(opLw, 4, 0, 16'h0008), 3);
        addEntry(rOp(fnAdd, 31, 4, 4, 0), 0);
        addEntry(iOp(opLw, 6, 0, 16'h0024), 3);
        addEntry(rOp(fnSub, 18, 1, 6, 0), 0);
        addEntry(iOp(opLw, 5, 0, 16'h0024), 3);
        addEntry(rOp(fnAdd, 19, 5, 0, 0), 1);
        predict();
        gapSum = 0;
        foreach (gapQ[i]) begin
            gapSum += gapQ[i];
        end
        cycleLimit = 4 * (prog.size() + gapSum) + 50;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            repeat (gapQ[i]) @(negedge clk);
            instr = prog[i];
            instrValid = 1'b1;
            issueCyc.push_back(cyc);
            pending.push_back(i);
            @(negedge clk);
            instrValid = 1'b0;
        end
        wait (passCount + failCount == prog.size());
        repeat (4) @(negedge clk); // any extra wbValid pulse shows up here.
        $display("%0d entries passed, %0d failed, %0d protocol errors",
                 passCount, failCount, protoErrors);
        if (failCount == 0 && protoErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/pipePkg.sv
src/fwdBus.sv
src/decodeBus.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/pipeTop.sv
verification/pipeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= pipeTb
RTL_TOP ?= pipeTop
FLIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
